//--- rv_pkg.sv
package rv_pkg;

	// Widths that carry a meaning
	typedef logic [31:0] word_t;
	typedef logic [11:0] pc_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [2:0]  dm_sel_t;
	typedef logic [1:0]  wb_sel_t;
	typedef logic [3:0]  byte_en_t;

	// RV32I major opcodes
	localparam logic [6:0] OP_R     = 7'b0110011;
	localparam logic [6:0] OP_I     = 7'b0010011;
	localparam logic [6:0] OP_LUI   = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL   = 7'b1101111;
	localparam logic [6:0] OP_JALR  = 7'b1100111;
	localparam logic [6:0] OP_STORE = 7'b0100011;

	// ALU operation codes, ADD is zero so a bubble is harmless
	localparam alu_op_t ALU_ADD   = 4'd0;
	localparam alu_op_t ALU_SUB   = 4'd1;
	localparam alu_op_t ALU_SLL   = 4'd2;
	localparam alu_op_t ALU_SLT   = 4'd3;
	localparam alu_op_t ALU_SLTU  = 4'd4;
	localparam alu_op_t ALU_XOR   = 4'd5;
	localparam alu_op_t ALU_SRL   = 4'd6;
	localparam alu_op_t ALU_SRA   = 4'd7;
	localparam alu_op_t ALU_OR    = 4'd8;
	localparam alu_op_t ALU_AND   = 4'd9;
	localparam alu_op_t ALU_PASSB = 4'd10;

	// Writeback source select
	localparam wb_sel_t WB_ALU  = 2'd0;
	localparam wb_sel_t WB_PC4  = 2'd1;
	localparam wb_sel_t WB_LOAD = 2'd2;

	// Store widths, same as funct3
	localparam dm_sel_t DM_BYTE = 3'b000;
	localparam dm_sel_t DM_HALF = 3'b001;
	localparam dm_sel_t DM_WORD = 3'b010;

endpackage

//--- id_exe_if.sv
`timescale 1ns/1ps

interface id_exe_if import rv_pkg::*; ();

	// Data fields
	pc_t       pc4;
	word_t     inst;
	word_t     rf_a;
	word_t     rf_b;
	word_t     imm;
	reg_addr_t rd;
	pc_t       pc;

	// Control fields
	alu_op_t   alu_op;
	logic      sel_op_a;
	logic      sel_op_b;
	logic      is_stype;
	logic      wr_en;
	dm_sel_t   dm_select;
	wb_sel_t   sel_data;
	logic [1:0] store_select;

	modport drive (
		output pc4, inst, rf_a, rf_b, imm, rd, pc,
		output alu_op, sel_op_a, sel_op_b, is_stype, wr_en, dm_select, sel_data,
		output store_select
	);

	modport sample (
		input pc4, inst, rf_a, rf_b, imm, rd, pc,
		input alu_op, sel_op_a, sel_op_b, is_stype, wr_en, dm_select, sel_data,
		input store_select
	);

endinterface

//--- regfile.sv
`timescale 1ns/1ps

module regfile import rv_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  reg_addr_t ra_a,
	input  reg_addr_t ra_b,
	output word_t     rd_a,
	output word_t     rd_b,
	input  logic      we,
	input  reg_addr_t wa,
	input  word_t     wd
);

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (!nrst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Write-through so a same-cycle reader sees the new value
	always_comb begin
		if (ra_a == '0)
			rd_a = '0;
		else if (we && wa == ra_a)
			rd_a = wd;
		else
			rd_a = regs[ra_a];

		if (ra_b == '0)
			rd_b = '0;
		else if (we && wa == ra_b)
			rd_b = wd;
		else
			rd_b = regs[ra_b];
	end

	a_x0_zero: assert property (@(posedge clk) disable iff (!nrst)
		(ra_a == '0 |-> rd_a == '0) and (ra_b == '0 |-> rd_b == '0));

endmodule

//--- id_decode.sv
`timescale 1ns/1ps

module id_decode import rv_pkg::*; (
	input  word_t     inst,
	input  pc_t       pc,
	output reg_addr_t ra_a,
	output reg_addr_t ra_b,
	input  word_t     rd_a,
	input  word_t     rd_b,
	id_exe_if.drive   dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_u;
	word_t      imm_j;

	function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			3'b000: op = alt ? ALU_SUB : ALU_ADD;
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: op = alt ? ALU_SRA : ALU_SRL;
			3'b110: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign ra_a   = inst[19:15];
	assign ra_b   = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// Fields that pass straight to the pipeline register
	assign dec.pc4  = pc + 12'd4;
	assign dec.inst = inst;
	assign dec.rf_a = rd_a;
	assign dec.rf_b = rd_b;
	assign dec.rd   = inst[11:7];
	assign dec.pc   = pc;

	always_comb begin
		dec.imm          = '0;
		dec.alu_op       = ALU_ADD;
		dec.sel_op_a     = 1'b0;
		dec.sel_op_b     = 1'b0;
		dec.is_stype     = 1'b0;
		dec.wr_en        = 1'b0;
		dec.dm_select    = '0;
		dec.sel_data     = WB_ALU;
		dec.store_select = '0;
		case (opcode)
			OP_R: begin
				dec.alu_op = funct_to_alu(funct3, inst[30]);
				dec.wr_en  = (inst[11:7] != '0);
			end
			OP_I: begin
				// Only the shift-right form uses bit 30 for the I-type
				dec.alu_op   = funct_to_alu(funct3, (funct3 == 3'b101) && inst[30]);
				dec.imm      = imm_i;
				dec.sel_op_b = 1'b1;
				dec.wr_en    = (inst[11:7] != '0);
			end
			OP_LUI: begin
				dec.alu_op   = ALU_PASSB;
				dec.imm      = imm_u;
				dec.sel_op_b = 1'b1;
				dec.wr_en    = (inst[11:7] != '0);
			end
			OP_AUIPC: begin
				dec.imm      = imm_u;
				dec.sel_op_a = 1'b1;
				dec.sel_op_b = 1'b1;
				dec.wr_en    = (inst[11:7] != '0);
			end
			OP_JAL, OP_JALR: begin
				dec.imm      = (opcode == OP_JAL) ? imm_j : imm_i;
				dec.sel_op_b = 1'b1;
				dec.sel_data = WB_PC4;
				dec.wr_en    = (inst[11:7] != '0);
			end
			OP_STORE: begin
				// SB, SH and SW only, wider funct3 stays a bubble
				if (funct3 == DM_BYTE || funct3 == DM_HALF || funct3 == DM_WORD) begin
					dec.imm          = imm_s;
					dec.sel_op_b     = 1'b1;
					dec.is_stype     = 1'b1;
					dec.dm_select    = funct3;
					dec.store_select = imm_s[1:0];
				end
			end
			default: ;
		endcase
	end

endmodule

//--- pipereg_id_exe.sv
`timescale 1ns/1ps

module pipereg_id_exe import rv_pkg::*; (
	input  logic     clk,
	input  logic     nrst,
	input  logic     flush,
	id_exe_if.sample id,
	id_exe_if.drive  exe
);

	always_ff @(posedge clk) begin
		// A flushed slot becomes an all-zero bubble
		if (!nrst || flush) begin
			exe.pc4          <= '0;
			exe.inst         <= '0;
			exe.rf_a         <= '0;
			exe.rf_b         <= '0;
			exe.imm          <= '0;
			exe.rd           <= '0;
			exe.pc           <= '0;
			exe.alu_op       <= '0;
			exe.sel_op_a     <= 1'b0;
			exe.sel_op_b     <= 1'b0;
			exe.is_stype     <= 1'b0;
			exe.wr_en        <= 1'b0;
			exe.dm_select    <= '0;
			exe.sel_data     <= '0;
			exe.store_select <= '0;
		end else begin
			exe.pc4          <= id.pc4;
			exe.inst         <= id.inst;
			exe.rf_a         <= id.rf_a;
			exe.rf_b         <= id.rf_b;
			exe.imm          <= id.imm;
			exe.rd           <= id.rd;
			exe.pc           <= id.pc;
			exe.alu_op       <= id.alu_op;
			exe.sel_op_a     <= id.sel_op_a;
			exe.sel_op_b     <= id.sel_op_b;
			exe.is_stype     <= id.is_stype;
			exe.wr_en        <= id.wr_en;
			exe.dm_select    <= id.dm_select;
			exe.sel_data     <= id.sel_data;
			exe.store_select <= id.store_select;
		end
	end

	a_flush_bubble: assert property (@(posedge clk) disable iff (!nrst)
		flush |=> (!exe.wr_en && !exe.is_stype));

endmodule

//--- exe_alu.sv
`timescale 1ns/1ps

module exe_alu import rv_pkg::*; (
	id_exe_if.sample exe,
	output word_t    alu_y,
	output word_t    st_addr,
	output word_t    st_data,
	output byte_en_t st_be
);

	word_t      op_a;
	word_t      op_b;
	logic [4:0] shamt;
	logic [1:0] lane;

	assign op_a  = exe.sel_op_a ? {20'b0, exe.pc} : exe.rf_a;
	assign op_b  = exe.sel_op_b ? exe.imm : exe.rf_b;
	assign shamt = op_b[4:0];

	always_comb begin
		case (exe.alu_op)
			ALU_ADD:   alu_y = op_a + op_b;
			ALU_SUB:   alu_y = op_a - op_b;
			ALU_SLL:   alu_y = op_a << shamt;
			ALU_SLT:   alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:  alu_y = {31'b0, op_a < op_b};
			ALU_XOR:   alu_y = op_a ^ op_b;
			ALU_SRL:   alu_y = op_a >> shamt;
			ALU_SRA:   alu_y = $signed(op_a) >>> shamt;
			ALU_OR:    alu_y = op_a | op_b;
			ALU_AND:   alu_y = op_a & op_b;
			ALU_PASSB: alu_y = op_b;
			default:   alu_y = '0;
		endcase
	end

	// Store lane from base and offset low bits
	assign st_addr = exe.rf_a + exe.imm;
	assign lane    = exe.rf_a[1:0] + exe.store_select;

	always_comb begin
		case (exe.dm_select)
			DM_BYTE: begin
				st_data = {4{exe.rf_b[7:0]}};
				st_be   = 4'b0001 << lane;
			end
			DM_HALF: begin
				st_data = {2{exe.rf_b[15:0]}};
				st_be   = lane[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				st_data = exe.rf_b;
				st_be   = 4'b1111;
			end
		endcase
	end

	always_comb begin
		a_half_align: assert final (!(exe.is_stype && exe.dm_select == DM_HALF) ||
			!st_addr[0]);
	end

endmodule

//--- exe_result.sv
`timescale 1ns/1ps

module exe_result import rv_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	id_exe_if.sample  exe,
	input  word_t     alu_y,
	input  word_t     st_addr,
	input  word_t     st_data,
	input  byte_en_t  st_be,
	output logic      wb_en,
	output reg_addr_t wb_rd,
	output word_t     wb_data,
	output pc_t       wb_pc,
	output logic      dm_wr,
	output word_t     dm_addr,
	output word_t     dm_wdata,
	output byte_en_t  dm_be
);

	word_t wb_next;

	// No load path in this slice
	always_comb begin
		case (exe.sel_data)
			WB_PC4:  wb_next = {20'b0, exe.pc4};
			WB_LOAD: wb_next = '0;
			default: wb_next = alu_y;
		endcase
	end

	// Strobes
	always_ff @(posedge clk) begin
		if (!nrst) begin
			wb_en <= 1'b0;
			dm_wr <= 1'b0;
		end else begin
			wb_en <= exe.wr_en;
			dm_wr <= exe.is_stype;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd    <= exe.rd;
		wb_data  <= wb_next;
		wb_pc    <= exe.pc;
		dm_addr  <= st_addr;
		dm_wdata <= st_data;
		dm_be    <= st_be;
	end

	a_wb_or_store: assert property (@(posedge clk) disable iff (!nrst)
		!(wb_en && dm_wr));

endmodule

//--- core_top.sv
`timescale 1ns/1ps

module core_top import rv_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  logic      flush,
	input  word_t     inst,
	input  pc_t       pc,
	output logic      wb_en,
	output reg_addr_t wb_rd,
	output word_t     wb_data,
	output pc_t       wb_pc,
	output logic      dm_wr,
	output word_t     dm_addr,
	output word_t     dm_wdata,
	output byte_en_t  dm_be
);

	reg_addr_t ra_a;
	reg_addr_t ra_b;
	word_t     rd_a;
	word_t     rd_b;
	word_t     alu_y;
	word_t     st_addr;
	word_t     st_data;
	byte_en_t  st_be;

	id_exe_if id_bus ();
	id_exe_if exe_bus ();

	// Write port fed back from the result stage
	regfile i_regfile (
		.clk  (clk),
		.nrst (nrst),
		.ra_a (ra_a),
		.ra_b (ra_b),
		.rd_a (rd_a),
		.rd_b (rd_b),
		.we   (wb_en),
		.wa   (wb_rd),
		.wd   (wb_data)
	);

	id_decode i_id_decode (
		.inst (inst),
		.pc   (pc),
		.ra_a (ra_a),
		.ra_b (ra_b),
		.rd_a (rd_a),
		.rd_b (rd_b),
		.dec  (id_bus)
	);

	pipereg_id_exe i_pipereg_id_exe (
		.clk   (clk),
		.nrst  (nrst),
		.flush (flush),
		.id    (id_bus),
		.exe   (exe_bus)
	);

	exe_alu i_exe_alu (
		.exe     (exe_bus),
		.alu_y   (alu_y),
		.st_addr (st_addr),
		.st_data (st_data),
		.st_be   (st_be)
	);

	exe_result i_exe_result (
		.clk      (clk),
		.nrst     (nrst),
		.exe      (exe_bus),
		.alu_y    (alu_y),
		.st_addr  (st_addr),
		.st_data  (st_data),
		.st_be    (st_be),
		.wb_en    (wb_en),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.wb_pc    (wb_pc),
		.dm_wr    (dm_wr),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata),
		.dm_be    (dm_be)
	);

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker import rv_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  logic      flush,
	input  word_t     inst,
	input  pc_t       pc,
	input  int        test_id,
	input  logic      wb_en,
	input  reg_addr_t wb_rd,
	input  word_t     wb_data,
	input  pc_t       wb_pc,
	input  logic      dm_wr,
	input  word_t     dm_addr,
	input  word_t     dm_wdata,
	input  byte_en_t  dm_be,
	output int        n_checks,
	output int        n_errors
);

	word_t     model_regs [0:31];
	// Slot 0 is about to be sampled, slot 1 has its results on the outputs now
	logic      s_wb    [0:1];
	logic      s_st    [0:1];
	reg_addr_t s_rd    [0:1];
	word_t     s_data  [0:1];
	pc_t       s_pc    [0:1];
	word_t     s_addr  [0:1];
	word_t     s_wdata [0:1];
	byte_en_t  s_be    [0:1];
	int        s_tid   [0:1];
	int        cur_tid;
	int        t_checks;
	int        t_errors;

	function automatic string test_name(input int id);
		case (id)
			0:       return "reset";
			1:       return "alu_ops";
			2:       return "upper_link";
			3:       return "stores";
			4:       return "flush_bubbles";
			default: return "drain";
		endcase
	endfunction

	// RV32I integer ops by funct3, alt selects SUB and SRA
	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic check(input string what, input word_t exp, input word_t act);
		n_checks++;
		t_checks++;
		if (exp !== act) begin
			n_errors++;
			t_errors++;
			$display("** Error: test %s, %s expected %h, actual %h",
				test_name(cur_tid), what, exp, act);
		end
	endtask

	task automatic predict(input word_t w, input pc_t p, input logic f, input int id);
		word_t      a;
		word_t      b;
		word_t      ea;
		word_t      imm_s;
		logic [2:0] f3;
		logic       writes;
		f3         = w[14:12];
		a          = model_regs[w[19:15]];
		b          = model_regs[w[24:20]];
		imm_s      = {{20{w[31]}}, w[31:25], w[11:7]};
		writes     = 1'b1;
		s_st[0]    = 1'b0;
		s_rd[0]    = w[11:7];
		s_pc[0]    = p;
		s_data[0]  = '0;
		s_addr[0]  = '0;
		s_wdata[0] = '0;
		s_be[0]    = '0;
		s_tid[0]   = id;
		case (w[6:0])
			OP_R:     s_data[0] = alu_ref(f3, w[30], a, b);
			// Bit 30 belongs to the immediate except for SRAI
			OP_I:     s_data[0] = alu_ref(f3, f3 == 3'd5 && w[30], a,
				{{20{w[31]}}, w[31:20]});
			OP_LUI:   s_data[0] = {w[31:12], 12'b0};
			OP_AUIPC: s_data[0] = {20'b0, p} + {w[31:12], 12'b0};
			OP_JAL, OP_JALR: s_data[0] = {20'b0, p + 12'd4};
			OP_STORE: begin
				writes = 1'b0;
				ea     = a + imm_s;
				if (f3 <= 3'd2) begin
					s_st[0]   = 1'b1;
					s_addr[0] = ea;
				end
				case (f3)
					3'd0: begin
						s_wdata[0] = {4{b[7:0]}};
						s_be[0]    = 4'b0001 << ea[1:0];
					end
					3'd1: begin
						s_wdata[0] = {2{b[15:0]}};
						s_be[0]    = ea[1] ? 4'b1100 : 4'b0011;
					end
					default: begin
						s_wdata[0] = b;
						s_be[0]    = 4'b1111;
					end
				endcase
			end
			default: writes = 1'b0;
		endcase
		s_wb[0] = writes && w[11:7] != 5'd0 && !f;
		if (f)
			s_st[0] = 1'b0;
	endtask

	task automatic compare_outputs();
		if (s_wb[1]) begin
			check("wb_en", 32'd1, {31'b0, wb_en});
			check("wb_rd", {27'b0, s_rd[1]}, {27'b0, wb_rd});
			check("wb_data", s_data[1], wb_data);
			check("wb_pc", {20'b0, s_pc[1]}, {20'b0, wb_pc});
			check("dm_wr", 32'd0, {31'b0, dm_wr});
		end else if (s_st[1]) begin
			check("dm_wr", 32'd1, {31'b0, dm_wr});
			check("dm_addr", s_addr[1], dm_addr);
			check("dm_wdata", s_wdata[1], dm_wdata);
			check("dm_be", {28'b0, s_be[1]}, {28'b0, dm_be});
			check("wb_en", 32'd0, {31'b0, wb_en});
		end else begin
			check("wb_en", 32'd0, {31'b0, wb_en});
			check("dm_wr", 32'd0, {31'b0, dm_wr});
		end
	endtask

	// Falling edge, inputs and registered outputs are both settled here
	always @(negedge clk) begin
		if (!nrst) begin
			for (int i = 0; i < 32; i++) begin
				model_regs[i] = '0;
			end
			for (int i = 0; i < 2; i++) begin
				s_wb[i]  = 1'b0;
				s_st[i]  = 1'b0;
				s_tid[i] = 0;
			end
			cur_tid  = 0;
			t_checks = 0;
			t_errors = 0;
			n_checks = 0;
			n_errors = 0;
		end else begin
			if (s_tid[1] != cur_tid) begin
				$display("Test %s: %0d checks, %0d errors",
					test_name(cur_tid), t_checks, t_errors);
				cur_tid  = s_tid[1];
				t_checks = 0;
				t_errors = 0;
			end
			compare_outputs();
			// Register write lands now, the next sampled instruction sees it
			if (s_wb[1])
				model_regs[s_rd[1]] = s_data[1];
			s_wb[1]    = s_wb[0];
			s_st[1]    = s_st[0];
			s_rd[1]    = s_rd[0];
			s_data[1]  = s_data[0];
			s_pc[1]    = s_pc[0];
			s_addr[1]  = s_addr[0];
			s_wdata[1] = s_wdata[0];
			s_be[1]    = s_be[0];
			s_tid[1]   = s_tid[0];
			predict(inst, pc, flush, test_id);
		end
	end

endmodule

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top import rv_pkg::*; ();

	localparam int RESET_CYCLES = 8;
	localparam int N_TESTS      = 4;
	localparam int N_PER_TEST   = 300;
	localparam int DRAIN_CYCLES = 4;
	// One instruction per cycle, plus reset, drain and some margin
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_TESTS * N_PER_TEST + DRAIN_CYCLES + 50;

	logic      clk;
	logic      nrst;
	logic      flush;
	word_t     inst;
	pc_t       pc;
	int        test_id;
	logic      wb_en;
	reg_addr_t wb_rd;
	word_t     wb_data;
	pc_t       wb_pc;
	logic      dm_wr;
	word_t     dm_addr;
	word_t     dm_wdata;
	byte_en_t  dm_be;
	int        n_checks;
	int        n_errors;
	int        seed_ret;

	core_top i_dut (.*);

	tb_checker i_checker (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic reg_addr_t pick_reg(input int hi);
		return reg_addr_t'($urandom_range(hi, 0));
	endfunction

	// R-type or I-type ALU op on registers x0 to x<hi>
	function automatic word_t gen_alu(input int hi);
		word_t       r;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		r   = $urandom;
		f3  = r[2:0];
		alt = r[3] && (f3 == 3'b000 || f3 == 3'b101);
		if (r[4])
			return {1'b0, alt, 5'b0, pick_reg(hi), pick_reg(hi), f3, pick_reg(hi), OP_R};
		imm = r[31:20];
		// Shift amounts keep the upper bits clear apart from the SRAI flag
		if (f3 == 3'b001 || f3 == 3'b101)
			imm = {1'b0, alt, 5'b0, r[24:20]};
		return {imm, pick_reg(hi), f3, pick_reg(hi), OP_I};
	endfunction

	function automatic word_t gen_upper_link();
		word_t r;
		r = $urandom;
		case (r[1:0])
			2'd0:    return {r[31:12], pick_reg(31), OP_LUI};
			2'd1:    return {r[31:12], pick_reg(31), OP_AUIPC};
			2'd2:    return {r[31:12], pick_reg(31), OP_JAL};
			default: return {r[31:20], pick_reg(31), 3'b000, pick_reg(31), OP_JALR};
		endcase
	endfunction

	// Halfword stores use x0 as base so the address stays even
	function automatic word_t gen_store();
		logic [11:0] off;
		reg_addr_t   base;
		logic [2:0]  w;
		off  = 12'($urandom);
		base = pick_reg(31);
		w    = 3'($urandom_range(2, 0));
		if (w == DM_HALF) begin
			base   = '0;
			off[0] = 1'b0;
		end else if (w == DM_WORD) begin
			off[1:0] = 2'b00;
		end
		return {off[11:5], pick_reg(31), base, w, off[4:0], OP_STORE};
	endfunction

	task automatic drive_one(input word_t w, input logic f, input int id);
		@(posedge clk);
		#2;
		inst    = w;
		flush   = f;
		test_id = id;
		pc      = pc + 12'd4;
	endtask

	task automatic run_test(input int id);
		word_t w;
		word_t r;
		logic  f;
		for (int n = 0; n < N_PER_TEST; n++) begin
			f = 1'b0;
			case (id)
				1: w = gen_alu(31);
				2: w = gen_upper_link();
				3: w = gen_store();
				default: begin
					// Few registers so neighbours depend on each other
					r = $urandom;
					case (r[2:0])
						3'd0: w = {r[31:7], 7'b0000011};
						3'd1: w = '0;
						3'd2: begin
							w = gen_alu(3);
							f = 1'b1;
						end
						default: w = gen_alu(3);
					endcase
				end
			endcase
			drive_one(w, f, id);
		end
	endtask

	initial begin
		nrst     = 1'b0;
		flush    = 1'b0;
		inst     = '0;
		pc       = '0;
		test_id  = 0;
		seed_ret = $urandom(32'h9cb);
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		nrst = 1'b1;
		for (int t = 1; t <= N_TESTS; t++) begin
			run_test(t);
		end
		// Bubbles carry the last results out to the checker
		for (int n = 0; n < DRAIN_CYCLES; n++) begin
			drive_one('0, 1'b0, N_TESTS + 1);
		end
		@(posedge clk);
		$display("Totals: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0 && n_checks > 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- tb.f
rv_pkg.sv
id_exe_if.sv
regfile.sv
id_decode.sv
pipereg_id_exe.sv
exe_alu.sv
exe_result.sv
core_top.sv
tb_checker.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
